/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
RUNFLAGS := +verilator+error+limit+1000
TOP      := tb_rv32i_core
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log

BIN  := $(BUILD)/V$(TOP)
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HDRS := $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* rv32i_adder.sv */
module rv32i_adder (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_vld,
  input  rv32i_arch_pkg::reg_data_t  i_a,
  input  rv32i_arch_pkg::reg_data_t  i_b,
  input  rv32i_arch_pkg::reg_idx_t   i_dst_idx,
  input  logic                       i_grant,
  output logic                       o_rdy,
  output logic                       o_vld,
  output rv32i_arch_pkg::reg_data_t  o_sum,
  output rv32i_arch_pkg::reg_idx_t   o_dst_idx
);

  // Output slot frees up when empty or leaving this cycle
  assign o_rdy = ~o_vld | i_grant;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_vld <= 1'b0;
    end else if (o_rdy) begin
      o_vld <= i_vld;
    end
  end

  // Carry out dropped, wraps modulo 2^32
  always_ff @(posedge clk) begin
    if (i_vld && o_rdy) begin
      o_sum     <= i_a + i_b;
      o_dst_idx <= i_dst_idx;
    end
  end

endmodule

/* rv32i_arch_pkg.sv */
`include "rv32i_macros.svh"

package rv32i_arch_pkg;

  // One register word
  typedef logic [`RV32I_REG_BW-1:0] reg_data_t;

  // Register index, also used as the wakeup tag
  typedef logic [$clog2(`RV32I_NUM_ARCH_REGS)-1:0] reg_idx_t;

endpackage

/* rv32i_core.sv */
`include "rv32i_macros.svh"

module rv32i_core (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_decode_vld,
  input  rv32i_exec_pkg::pu_id_t     i_pu_id,
  input  logic                       i_rs1_vld,
  input  rv32i_arch_pkg::reg_idx_t   i_src1_arch_rf_idx,
  input  logic                       i_rs2_vld,
  input  rv32i_arch_pkg::reg_idx_t   i_src2_arch_rf_idx,
  input  rv32i_arch_pkg::reg_idx_t   i_dst_arch_rf_idx,
  input  rv32i_arch_pkg::reg_data_t  i_imm,
  output logic                       o_rdy,
  output logic                       o_wb_vld,
  output rv32i_arch_pkg::reg_idx_t   o_wb_arch_rf_idx,
  output rv32i_arch_pkg::reg_data_t  o_wb_data
);

  // ==========================================================
  // Interconnect
  // ==========================================================
  rv32i_arch_pkg::reg_idx_t   src1_idx;
  rv32i_arch_pkg::reg_idx_t   src2_idx;
  logic                       src1_ready;
  logic                       src2_ready;
  rv32i_arch_pkg::reg_data_t  src1_data;
  rv32i_arch_pkg::reg_data_t  src2_data;
  logic                       dst_busy;
  logic                       set_busy;

  rv32i_exec_pkg::pu_vec_t    rs_push;
  rv32i_exec_pkg::pu_vec_t    rs_full;
  logic                       disp_src1_vld;
  rv32i_arch_pkg::reg_data_t  disp_src1_value;
  logic                       disp_src2_vld;
  rv32i_arch_pkg::reg_data_t  disp_src2_value;
  rv32i_arch_pkg::reg_idx_t   disp_dst_idx;

  // Station issue side, one set per PU
  rv32i_exec_pkg::pu_vec_t    issue_vld;
  rv32i_exec_pkg::pu_vec_t    pu_rdy;
  rv32i_arch_pkg::reg_data_t  add_src1;
  rv32i_arch_pkg::reg_data_t  add_src2;
  rv32i_arch_pkg::reg_idx_t   add_issue_dst;
  rv32i_arch_pkg::reg_data_t  mult_src1;
  rv32i_arch_pkg::reg_data_t  mult_src2;
  rv32i_arch_pkg::reg_idx_t   mult_issue_dst;

  // PU results toward write-back
  rv32i_exec_pkg::pu_vec_t    pu_vld;
  rv32i_exec_pkg::pu_vec_t    wb_grant;
  rv32i_arch_pkg::reg_data_t  add_sum;
  rv32i_arch_pkg::reg_idx_t   add_dst;
  rv32i_arch_pkg::reg_data_t  mult_product;
  rv32i_arch_pkg::reg_idx_t   mult_dst;

  // ==========================================================
  // Register file and dispatch
  // ==========================================================
  rv32i_register_file u_register_file (
    .clk,
    .i_reset,
    .i_src1_idx     (src1_idx),
    .i_src2_idx     (src2_idx),
    .i_dst_idx      (disp_dst_idx),
    .i_set_busy     (set_busy),
    .i_set_busy_idx (disp_dst_idx),
    .i_wb_vld       (o_wb_vld),
    .i_wb_idx       (o_wb_arch_rf_idx),
    .i_wb_data      (o_wb_data),
    .o_src1_ready   (src1_ready),
    .o_src2_ready   (src2_ready),
    .o_dst_busy     (dst_busy),
    .o_src1_data    (src1_data),
    .o_src2_data    (src2_data)
  );

  rv32i_dispatch u_dispatch (
    .clk,
    .i_reset,
    .i_decode_vld,
    .i_pu_id,
    .i_rs1_vld,
    .i_src1_arch_rf_idx,
    .i_rs2_vld,
    .i_src2_arch_rf_idx,
    .i_dst_arch_rf_idx,
    .i_imm,
    .i_src1_ready   (src1_ready),
    .i_src1_data    (src1_data),
    .i_src2_ready   (src2_ready),
    .i_src2_data    (src2_data),
    .i_dst_busy     (dst_busy),
    .i_wb_vld       (o_wb_vld),
    .i_wb_idx       (o_wb_arch_rf_idx),
    .i_wb_data      (o_wb_data),
    .i_rs_full      (rs_full),
    .o_rdy,
    .o_src1_idx     (src1_idx),
    .o_src2_idx     (src2_idx),
    .o_rs_push      (rs_push),
    .o_src1_vld     (disp_src1_vld),
    .o_src1_value   (disp_src1_value),
    .o_src2_vld     (disp_src2_vld),
    .o_src2_value   (disp_src2_value),
    .o_dst_idx      (disp_dst_idx),
    .o_set_busy     (set_busy)
  );

  // ==========================================================
  // Adder path
  // ==========================================================
  rv32i_reservation_station #(
    .DEPTH (`RV32I_RS_DEPTH)
  ) u_add_rsrv_sttn (
    .clk,
    .i_reset,
    .i_push       (rs_push[rv32i_exec_pkg::PU_ADD]),
    .i_src1_vld   (disp_src1_vld),
    .i_src1_value (disp_src1_value),
    .i_src2_vld   (disp_src2_vld),
    .i_src2_value (disp_src2_value),
    .i_dst_idx    (disp_dst_idx),
    .i_wb_vld     (o_wb_vld),
    .i_wb_idx     (o_wb_arch_rf_idx),
    .i_wb_data    (o_wb_data),
    .i_pu_rdy     (pu_rdy[rv32i_exec_pkg::PU_ADD]),
    .o_full       (rs_full[rv32i_exec_pkg::PU_ADD]),
    .o_vld        (issue_vld[rv32i_exec_pkg::PU_ADD]),
    .o_src1       (add_src1),
    .o_src2       (add_src2),
    .o_dst_idx    (add_issue_dst)
  );

  rv32i_adder u_adder (
    .clk,
    .i_reset,
    .i_vld     (issue_vld[rv32i_exec_pkg::PU_ADD]),
    .i_a       (add_src1),
    .i_b       (add_src2),
    .i_dst_idx (add_issue_dst),
    .i_grant   (wb_grant[rv32i_exec_pkg::PU_ADD]),
    .o_rdy     (pu_rdy[rv32i_exec_pkg::PU_ADD]),
    .o_vld     (pu_vld[rv32i_exec_pkg::PU_ADD]),
    .o_sum     (add_sum),
    .o_dst_idx (add_dst)
  );

  // ==========================================================
  // Multiplier path
  // ==========================================================
  rv32i_reservation_station #(
    .DEPTH (`RV32I_RS_DEPTH)
  ) u_mult_rsrv_sttn (
    .clk,
    .i_reset,
    .i_push       (rs_push[rv32i_exec_pkg::PU_MULT]),
    .i_src1_vld   (disp_src1_vld),
    .i_src1_value (disp_src1_value),
    .i_src2_vld   (disp_src2_vld),
    .i_src2_value (disp_src2_value),
    .i_dst_idx    (disp_dst_idx),
    .i_wb_vld     (o_wb_vld),
    .i_wb_idx     (o_wb_arch_rf_idx),
    .i_wb_data    (o_wb_data),
    .i_pu_rdy     (pu_rdy[rv32i_exec_pkg::PU_MULT]),
    .o_full       (rs_full[rv32i_exec_pkg::PU_MULT]),
    .o_vld        (issue_vld[rv32i_exec_pkg::PU_MULT]),
    .o_src1       (mult_src1),
    .o_src2       (mult_src2),
    .o_dst_idx    (mult_issue_dst)
  );

  rv32i_multiplier_pipelined u_multiplier (
    .clk,
    .i_reset,
    .i_vld          (issue_vld[rv32i_exec_pkg::PU_MULT]),
    .i_multiplicand (mult_src1),
    .i_multiplier   (mult_src2),
    .i_dst_idx      (mult_issue_dst),
    .i_grant        (wb_grant[rv32i_exec_pkg::PU_MULT]),
    .o_rdy          (pu_rdy[rv32i_exec_pkg::PU_MULT]),
    .o_vld          (pu_vld[rv32i_exec_pkg::PU_MULT]),
    .o_product      (mult_product),
    .o_dst_idx      (mult_dst)
  );

  // ==========================================================
  // Write-back
  // ==========================================================
  rv32i_writeback_arbiter u_wb_arbiter (
    .clk,
    .i_reset,
    .i_req       (pu_vld),
    .i_add_data  (add_sum),
    .i_add_idx   (add_dst),
    .i_mult_data (mult_product),
    .i_mult_idx  (mult_dst),
    .o_grant     (wb_grant),
    .o_wb_vld,
    .o_wb_idx    (o_wb_arch_rf_idx),
    .o_wb_data
  );

endmodule

/* rv32i_core_assert.sv */
`include "rv32i_macros.svh"

module rv32i_core_assert (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_decode_vld,
  input  rv32i_exec_pkg::pu_id_t     i_pu_id,
  input  logic                       o_rdy,
  input  logic                       o_wb_vld,
  input  rv32i_exec_pkg::pu_vec_t    issue_vld,
  input  rv32i_exec_pkg::pu_vec_t    pu_rdy,
  input  rv32i_exec_pkg::pu_vec_t    pu_vld,
  input  rv32i_exec_pkg::pu_vec_t    wb_grant,
  input  rv32i_arch_pkg::reg_data_t  add_sum,
  input  rv32i_arch_pkg::reg_idx_t   add_dst,
  input  rv32i_arch_pkg::reg_data_t  mult_product,
  input  rv32i_arch_pkg::reg_idx_t   mult_dst
);

  int n_fail = 0;

  // Entries accepted but not yet issued, per station
  int   occupancy [`RV32I_NUM_PUS];
  logic sel_full;

  always_ff @(posedge clk) begin
    for (int p = 0; p < `RV32I_NUM_PUS; p++) begin
      if (i_reset) begin
        occupancy[p] <= 0;
      end else begin
        occupancy[p] <= occupancy[p]
            + ((i_decode_vld && o_rdy && int'(i_pu_id) == p) ? 1 : 0)
            - ((issue_vld[p] && pu_rdy[p]) ? 1 : 0);
      end
    end
  end

  assign sel_full = (occupancy[i_pu_id] == `RV32I_RS_DEPTH);

  // ==========================================================
  // Reset and write-back bus
  // ==========================================================
  a_reset_quiet: assert property (@(posedge clk)
      $past(i_reset) |-> !o_rdy && !o_wb_vld)
    else begin
      $error("o_rdy or o_wb_vld high during reset");
      n_fail++;
    end

  // Single result per cycle, granted unit is a requester, any request is served
  a_one_result: assert property (@(posedge clk) disable iff (i_reset)
      $onehot0(wb_grant) && ((wb_grant & ~pu_vld) == '0) &&
      (o_wb_vld == (|pu_vld)))
    else begin
      $error("write-back grant does not match the unit requests");
      n_fail++;
    end

  // ==========================================================
  // Back-pressure
  // ==========================================================
  a_add_hold: assert property (@(posedge clk) disable iff (i_reset)
      pu_vld[rv32i_exec_pkg::PU_ADD] && !wb_grant[rv32i_exec_pkg::PU_ADD] |=>
      pu_vld[rv32i_exec_pkg::PU_ADD] && $stable(add_sum) && $stable(add_dst))
    else begin
      $error("adder result changed while waiting for its grant");
      n_fail++;
    end

  a_mult_hold: assert property (@(posedge clk) disable iff (i_reset)
      pu_vld[rv32i_exec_pkg::PU_MULT] && !wb_grant[rv32i_exec_pkg::PU_MULT] |=>
      pu_vld[rv32i_exec_pkg::PU_MULT] && $stable(mult_product) && $stable(mult_dst))
    else begin
      $error("multiplier result changed while waiting for its grant");
      n_fail++;
    end

  // Round robin between two steady requesters
  a_alternate: assert property (@(posedge clk) disable iff (i_reset)
      (&pu_vld) && $past(&pu_vld) |-> wb_grant != $past(wb_grant))
    else begin
      $error("grant did not alternate between two requesting units");
      n_fail++;
    end

  a_full_stall: assert property (@(posedge clk) disable iff (i_reset)
      sel_full |-> !o_rdy)
    else begin
      $error("o_rdy high while the selected station holds its full count of entries");
      n_fail++;
    end

endmodule

/* rv32i_dispatch.sv */
module rv32i_dispatch (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_decode_vld,
  input  rv32i_exec_pkg::pu_id_t     i_pu_id,
  input  logic                       i_rs1_vld,
  input  rv32i_arch_pkg::reg_idx_t   i_src1_arch_rf_idx,
  input  logic                       i_rs2_vld,
  input  rv32i_arch_pkg::reg_idx_t   i_src2_arch_rf_idx,
  input  rv32i_arch_pkg::reg_idx_t   i_dst_arch_rf_idx,
  input  rv32i_arch_pkg::reg_data_t  i_imm,
  input  logic                       i_src1_ready,
  input  rv32i_arch_pkg::reg_data_t  i_src1_data,
  input  logic                       i_src2_ready,
  input  rv32i_arch_pkg::reg_data_t  i_src2_data,
  input  logic                       i_dst_busy,
  input  logic                       i_wb_vld,
  input  rv32i_arch_pkg::reg_idx_t   i_wb_idx,
  input  rv32i_arch_pkg::reg_data_t  i_wb_data,
  input  rv32i_exec_pkg::pu_vec_t    i_rs_full,
  output logic                       o_rdy,
  output rv32i_arch_pkg::reg_idx_t   o_src1_idx,
  output rv32i_arch_pkg::reg_idx_t   o_src2_idx,
  output rv32i_exec_pkg::pu_vec_t    o_rs_push,
  output logic                       o_src1_vld,
  output rv32i_arch_pkg::reg_data_t  o_src1_value,
  output logic                       o_src2_vld,
  output rv32i_arch_pkg::reg_data_t  o_src2_value,
  output rv32i_arch_pkg::reg_idx_t   o_dst_idx,
  output logic                       o_set_busy
);

  localparam int DW = $bits(rv32i_arch_pkg::reg_data_t);

  logic run_q;
  logic accept;

  // Returns {valid, value}; when not valid the value carries the tag
  function automatic logic [DW:0] pick_operand(
    input logic                      use_reg,
    input rv32i_arch_pkg::reg_idx_t  idx,
    input logic                      rf_ready,
    input rv32i_arch_pkg::reg_data_t rf_data,
    input rv32i_arch_pkg::reg_data_t alt,
    input logic                      wb_vld,
    input rv32i_arch_pkg::reg_idx_t  wb_idx,
    input rv32i_arch_pkg::reg_data_t wb_data
  );
    if (!use_reg) begin
      return {1'b1, alt};
    end
    if (wb_vld && wb_idx == idx) begin
      return {1'b1, wb_data};
    end
    if (rf_ready) begin
      return {1'b1, rf_data};
    end
    return {1'b0, rv32i_arch_pkg::reg_data_t'(idx)};
  endfunction

  // Held low through reset and released on the first cycle after it
  always_ff @(posedge clk) begin
    if (i_reset) begin
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
    end
  end

  assign o_src1_idx = i_src1_arch_rf_idx;
  assign o_src2_idx = i_src2_arch_rf_idx;

  assign {o_src1_vld, o_src1_value} = pick_operand(i_rs1_vld, i_src1_arch_rf_idx,
      i_src1_ready, i_src1_data, '0, i_wb_vld, i_wb_idx, i_wb_data);
  assign {o_src2_vld, o_src2_value} = pick_operand(i_rs2_vld, i_src2_arch_rf_idx,
      i_src2_ready, i_src2_data, i_imm, i_wb_vld, i_wb_idx, i_wb_data);

  // One result in flight per register keeps the tags unique
  assign o_rdy  = run_q & ~i_dst_busy & ~i_rs_full[i_pu_id];
  assign accept = i_decode_vld & o_rdy;

  assign o_rs_push  = {$bits(o_rs_push){accept}} & (rv32i_exec_pkg::pu_vec_t'(1) << i_pu_id);
  assign o_dst_idx  = i_dst_arch_rf_idx;
  assign o_set_busy = accept;

endmodule

/* rv32i_exec_pkg.sv */
`include "rv32i_macros.svh"

package rv32i_exec_pkg;

  // Processing unit selector carried by each decoded instruction
  typedef enum logic [$clog2(`RV32I_NUM_PUS)-1:0] {
    PU_ADD  = 0,
    PU_MULT = 1
  } pu_id_t;

  // One bit per processing unit
  typedef logic [`RV32I_NUM_PUS-1:0] pu_vec_t;

endpackage

/* rv32i_macros.svh */
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// Datapath width
`define RV32I_REG_BW 32

// Architectural register count
`define RV32I_NUM_ARCH_REGS 32

// Processing units and their station depth
`define RV32I_NUM_PUS 2
`define RV32I_RS_DEPTH 2

// Multiplier pipeline depth
`define RV32I_MULT_STAGES 3

`endif

/* rv32i_multiplier_pipelined.sv */
`include "rv32i_macros.svh"

module rv32i_multiplier_pipelined (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_vld,
  input  rv32i_arch_pkg::reg_data_t  i_multiplicand,
  input  rv32i_arch_pkg::reg_data_t  i_multiplier,
  input  rv32i_arch_pkg::reg_idx_t   i_dst_idx,
  input  logic                       i_grant,
  output logic                       o_rdy,
  output logic                       o_vld,
  output rv32i_arch_pkg::reg_data_t  o_product,
  output rv32i_arch_pkg::reg_idx_t   o_dst_idx
);

  localparam int STAGES = `RV32I_MULT_STAGES;
  localparam int HALF   = $bits(rv32i_arch_pkg::reg_data_t) / 2;

  logic [STAGES-1:0]          vld_q;
  rv32i_arch_pkg::reg_idx_t   dst_q  [STAGES];
  rv32i_arch_pkg::reg_data_t  lo_q;
  logic [HALF-1:0]            hi_q;
  rv32i_arch_pkg::reg_data_t  prod_q [1:STAGES-1];
  logic                       advance;

  // Whole pipe freezes while the last stage waits for a grant
  assign advance = ~vld_q[STAGES-1] | i_grant;
  assign o_rdy   = advance;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      vld_q <= '0;
    end else if (advance) begin
      vld_q <= {vld_q[STAGES-2:0], i_vld};
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      // Stage 0 splits the multiplier into halves
      lo_q     <= i_multiplicand * i_multiplier[HALF-1:0];
      hi_q     <= i_multiplicand[HALF-1:0] * i_multiplier[2*HALF-1:HALF];
      dst_q[0] <= i_dst_idx;
      // Stage 1 sums the partials, only the low word is kept
      prod_q[1] <= lo_q + {hi_q, {HALF{1'b0}}};
      dst_q[1]  <= dst_q[0];
      for (int s = 2; s < STAGES; s++) begin
        prod_q[s] <= prod_q[s-1];
        dst_q[s]  <= dst_q[s-1];
      end
    end
  end

  assign o_vld     = vld_q[STAGES-1];
  assign o_product = prod_q[STAGES-1];
  assign o_dst_idx = dst_q[STAGES-1];

endmodule

/* rv32i_register_file.sv */
`include "rv32i_macros.svh"

module rv32i_register_file (
  input  logic                       clk,
  input  logic                       i_reset,
  input  rv32i_arch_pkg::reg_idx_t   i_src1_idx,
  input  rv32i_arch_pkg::reg_idx_t   i_src2_idx,
  input  rv32i_arch_pkg::reg_idx_t   i_dst_idx,
  input  logic                       i_set_busy,
  input  rv32i_arch_pkg::reg_idx_t   i_set_busy_idx,
  input  logic                       i_wb_vld,
  input  rv32i_arch_pkg::reg_idx_t   i_wb_idx,
  input  rv32i_arch_pkg::reg_data_t  i_wb_data,
  output logic                       o_src1_ready,
  output logic                       o_src2_ready,
  output logic                       o_dst_busy,
  output rv32i_arch_pkg::reg_data_t  o_src1_data,
  output rv32i_arch_pkg::reg_data_t  o_src2_data
);

  rv32i_arch_pkg::reg_data_t        regs_q [`RV32I_NUM_ARCH_REGS];
  logic [`RV32I_NUM_ARCH_REGS-1:0]  busy_q;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      busy_q <= '0;
      for (int r = 0; r < `RV32I_NUM_ARCH_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      // Write-back lands the value and releases the register
      if (i_wb_vld && i_wb_idx != '0) begin
        regs_q[i_wb_idx] <= i_wb_data;
        busy_q[i_wb_idx] <= 1'b0;
      end
      // Register 0 never gets a pending result
      if (i_set_busy && i_set_busy_idx != '0) begin
        busy_q[i_set_busy_idx] <= 1'b1;
      end
    end
  end

  // x0 stays zero and never busy
  assign o_src1_ready = ~busy_q[i_src1_idx];
  assign o_src2_ready = ~busy_q[i_src2_idx];
  assign o_src1_data  = regs_q[i_src1_idx];
  assign o_src2_data  = regs_q[i_src2_idx];
  assign o_dst_busy   = busy_q[i_dst_idx];

endmodule

/* rv32i_reservation_station.sv */
`include "rv32i_macros.svh"

module rv32i_reservation_station #(
  parameter int DEPTH = `RV32I_RS_DEPTH
) (
  input  logic                       clk,
  input  logic                       i_reset,
  input  logic                       i_push,
  input  logic                       i_src1_vld,
  input  rv32i_arch_pkg::reg_data_t  i_src1_value,
  input  logic                       i_src2_vld,
  input  rv32i_arch_pkg::reg_data_t  i_src2_value,
  input  rv32i_arch_pkg::reg_idx_t   i_dst_idx,
  input  logic                       i_wb_vld,
  input  rv32i_arch_pkg::reg_idx_t   i_wb_idx,
  input  rv32i_arch_pkg::reg_data_t  i_wb_data,
  input  logic                       i_pu_rdy,
  output logic                       o_full,
  output logic                       o_vld,
  output rv32i_arch_pkg::reg_data_t  o_src1,
  output rv32i_arch_pkg::reg_data_t  o_src2,
  output rv32i_arch_pkg::reg_idx_t   o_dst_idx
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic                       src1_vld_q [DEPTH];
  logic                       src2_vld_q [DEPTH];
  rv32i_arch_pkg::reg_data_t  src1_q     [DEPTH];
  rv32i_arch_pkg::reg_data_t  src2_q     [DEPTH];
  rv32i_arch_pkg::reg_idx_t   dst_q      [DEPTH];

  logic [PTR_W-1:0]  head_q;
  logic [PTR_W-1:0]  tail_q;
  logic [CNT_W-1:0]  count_q;
  logic              pop;

  // ==========================================================
  // Queue control
  // ==========================================================
  always_ff @(posedge clk) begin
    if (i_reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (i_push) begin
        tail_q <= (tail_q == PTR_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
      end
      if (pop) begin
        head_q <= (head_q == PTR_W'(DEPTH - 1)) ? '0 : head_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(i_push) - CNT_W'(pop);
    end
  end

  // ==========================================================
  // Entry storage and tag wakeup
  // ==========================================================
  always_ff @(posedge clk) begin
    for (int e = 0; e < DEPTH; e++) begin
      if (i_wb_vld && !src1_vld_q[e] &&
          rv32i_arch_pkg::reg_idx_t'(src1_q[e]) == i_wb_idx) begin
        src1_vld_q[e] <= 1'b1;
        src1_q[e]     <= i_wb_data;
      end
      if (i_wb_vld && !src2_vld_q[e] &&
          rv32i_arch_pkg::reg_idx_t'(src2_q[e]) == i_wb_idx) begin
        src2_vld_q[e] <= 1'b1;
        src2_q[e]     <= i_wb_data;
      end
    end
    // Tail slot is free, so a new entry overrides any stale capture
    if (i_push) begin
      src1_vld_q[tail_q] <= i_src1_vld;
      src1_q[tail_q]     <= i_src1_value;
      src2_vld_q[tail_q] <= i_src2_vld;
      src2_q[tail_q]     <= i_src2_value;
      dst_q[tail_q]      <= i_dst_idx;
    end
  end

  // Head only, so results of one PU leave in order
  assign o_vld     = (count_q != '0) & src1_vld_q[head_q] & src2_vld_q[head_q];
  assign pop       = o_vld & i_pu_rdy;
  assign o_full    = (count_q == CNT_W'(DEPTH));
  assign o_src1    = src1_q[head_q];
  assign o_src2    = src2_q[head_q];
  assign o_dst_idx = dst_q[head_q];

endmodule

/* rv32i_writeback_arbiter.sv */
module rv32i_writeback_arbiter (
  input  logic                       clk,
  input  logic                       i_reset,
  input  rv32i_exec_pkg::pu_vec_t    i_req,
  input  rv32i_arch_pkg::reg_data_t  i_add_data,
  input  rv32i_arch_pkg::reg_idx_t   i_add_idx,
  input  rv32i_arch_pkg::reg_data_t  i_mult_data,
  input  rv32i_arch_pkg::reg_idx_t   i_mult_idx,
  output rv32i_exec_pkg::pu_vec_t    o_grant,
  output logic                       o_wb_vld,
  output rv32i_arch_pkg::reg_idx_t   o_wb_idx,
  output rv32i_arch_pkg::reg_data_t  o_wb_data
);

  localparam int NUM  = $bits(rv32i_exec_pkg::pu_vec_t);
  localparam int ID_W = $bits(rv32i_exec_pkg::pu_id_t);

  logic [ID_W-1:0] ptr_q;
  logic [ID_W-1:0] sel;

  // Scan from the pointer; the nearest requester wins
  always_comb begin
    int cand;
    o_grant = '0;
    sel     = ptr_q;
    for (int k = NUM - 1; k >= 0; k--) begin
      cand = (int'(ptr_q) + k) % NUM;
      if (i_req[cand]) begin
        o_grant       = '0;
        o_grant[cand] = 1'b1;
        sel           = ID_W'(cand);
      end
    end
  end

  assign o_wb_vld = |o_grant;

  // Pointer steps past the winner
  always_ff @(posedge clk) begin
    if (i_reset) begin
      ptr_q <= '0;
    end else if (o_wb_vld) begin
      ptr_q <= (int'(sel) == NUM - 1) ? '0 : sel + 1'b1;
    end
  end

  always_comb begin
    case (rv32i_exec_pkg::pu_id_t'(sel))
      rv32i_exec_pkg::PU_MULT: begin
        o_wb_idx  = i_mult_idx;
        o_wb_data = i_mult_data;
      end
      default: begin
        o_wb_idx  = i_add_idx;
        o_wb_data = i_add_data;
      end
    endcase
  end

endmodule

/* sim.f */
+incdir+.
rv32i_arch_pkg.sv
rv32i_exec_pkg.sv
rv32i_register_file.sv
rv32i_dispatch.sv
rv32i_reservation_station.sv
rv32i_adder.sv
rv32i_multiplier_pipelined.sv
rv32i_writeback_arbiter.sv
rv32i_core.sv
rv32i_core_assert.sv
tb_rv32i_core.sv

/* tb_rv32i_core.sv */
`include "rv32i_macros.svh"

module tb_rv32i_core;

  localparam int NUM_INSTR   = 78;
  localparam int CYCLE_LIMIT = NUM_INSTR * 40 + 200;

  logic                       clk;
  logic                       i_reset;
  logic                       i_decode_vld;
  rv32i_exec_pkg::pu_id_t     i_pu_id;
  logic                       i_rs1_vld;
  rv32i_arch_pkg::reg_idx_t   i_src1_arch_rf_idx;
  logic                       i_rs2_vld;
  rv32i_arch_pkg::reg_idx_t   i_src2_arch_rf_idx;
  rv32i_arch_pkg::reg_idx_t   i_dst_arch_rf_idx;
  rv32i_arch_pkg::reg_data_t  i_imm;
  logic                       o_rdy;
  logic                       o_wb_vld;
  rv32i_arch_pkg::reg_idx_t   o_wb_arch_rf_idx;
  rv32i_arch_pkg::reg_data_t  o_wb_data;

  // Reference model state, indexed by architectural register
  rv32i_arch_pkg::reg_data_t  model    [`RV32I_NUM_ARCH_REGS];
  rv32i_arch_pkg::reg_data_t  expected [`RV32I_NUM_ARCH_REGS];
  logic                       pending  [`RV32I_NUM_ARCH_REGS];

  logic [31:0] lfsr_q = 32'h547612d4;
  int          errors = 0;
  int          n_accepted = 0;
  int          n_wb = 0;
  int          tests_run = 0;
  int          acc_mark = 0;
  int          err_mark = 0;
  int          cycles = 0;

  rv32i_core UUT (.*);

  bind rv32i_core rv32i_core_assert u_core_assert (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_decode_vld (i_decode_vld),
    .i_pu_id      (i_pu_id),
    .o_rdy        (o_rdy),
    .o_wb_vld     (o_wb_vld),
    .issue_vld    (issue_vld),
    .pu_rdy       (pu_rdy),
    .pu_vld       (pu_vld),
    .wb_grant     (wb_grant),
    .add_sum      (add_sum),
    .add_dst      (add_dst),
    .mult_product (mult_product),
    .mult_dst     (mult_dst)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================
  // Stimulus helpers
  // ==========================================================
  // Taps 32, 22, 2, 1; one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // Nonzero register in 1 .. 2**bits
  function automatic rv32i_arch_pkg::reg_idx_t pick_reg(input int bits);
    return rv32i_arch_pkg::reg_idx_t'(rand_bits(bits) + 1);
  endfunction

  function automatic rv32i_exec_pkg::pu_id_t pick_pu();
    return rand_bits(1) ? rv32i_exec_pkg::PU_MULT : rv32i_exec_pkg::PU_ADD;
  endfunction

  function automatic int total_errors();
    return errors + UUT.u_core_assert.n_fail;
  endfunction

  task automatic send(input rv32i_exec_pkg::pu_id_t pu, input logic rs1_vld,
                      input rv32i_arch_pkg::reg_idx_t src1, input logic rs2_vld,
                      input rv32i_arch_pkg::reg_idx_t src2,
                      input rv32i_arch_pkg::reg_idx_t dst,
                      input rv32i_arch_pkg::reg_data_t imm);
    rv32i_arch_pkg::reg_data_t a;
    rv32i_arch_pkg::reg_data_t b;
    logic                      dst_in_flight;
    logic                      taken;
    @(negedge clk);
    i_decode_vld       = 1'b1;
    i_pu_id            = pu;
    i_rs1_vld          = rs1_vld;
    i_src1_arch_rf_idx = src1;
    i_rs2_vld          = rs2_vld;
    i_src2_arch_rf_idx = src2;
    i_dst_arch_rf_idx  = dst;
    i_imm              = imm;
    taken              = 1'b0;
    // Hold the instruction until the core takes it
    while (!taken) begin
      dst_in_flight = pending[dst];
      @(posedge clk);
      if (dst_in_flight) begin
        assert (!o_rdy) else begin
          $display("o_rdy high while x%0d still waits for its result", dst);
          errors++;
        end
      end
      taken = o_rdy;
      if (!taken) begin
        @(negedge clk);
      end
    end
    a = rs1_vld ? model[src1] : '0;
    b = rs2_vld ? model[src2] : imm;
    expected[dst] = (pu == rv32i_exec_pkg::PU_MULT) ? a * b : a + b;
    model[dst]    = expected[dst];
    pending[dst]  = 1'b1;
    n_accepted++;
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    i_decode_vld = 1'b0;
    while (n_wb < n_accepted) begin
      @(negedge clk);
    end
    tests_run++;
    $display("test %0d %s: %0d instructions, %0d errors", tests_run, name,
             n_accepted - acc_mark, total_errors() - err_mark);
    acc_mark = n_accepted;
    err_mark = total_errors();
  endtask

  // ==========================================================
  // Write-back checker and run limit
  // ==========================================================
  always @(posedge clk) begin
    if (!i_reset && o_wb_vld) begin
      assert (pending[o_wb_arch_rf_idx]) else begin
        $display("Write-back to x%0d with no result in flight", o_wb_arch_rf_idx);
        errors++;
      end
      assert (o_wb_data == expected[o_wb_arch_rf_idx]) else begin
        $display("Mismatch o_wb_data x%0d: got 0x%08h expected 0x%08h",
                 o_wb_arch_rf_idx, o_wb_data, expected[o_wb_arch_rf_idx]);
        errors++;
      end
      pending[o_wb_arch_rf_idx] = 1'b0;
      n_wb++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without draining", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial begin
    rv32i_exec_pkg::pu_id_t     pu;
    logic                       v1;
    logic                       v2;
    rv32i_arch_pkg::reg_idx_t   s1;
    rv32i_arch_pkg::reg_idx_t   s2;
    rv32i_arch_pkg::reg_idx_t   dst;
    rv32i_arch_pkg::reg_data_t  imm;
    i_reset            = 1'b1;
    i_decode_vld       = 1'b0;
    i_pu_id            = rv32i_exec_pkg::PU_ADD;
    i_rs1_vld          = 1'b0;
    i_src1_arch_rf_idx = '0;
    i_rs2_vld          = 1'b0;
    i_src2_arch_rf_idx = '0;
    i_dst_arch_rf_idx  = '0;
    i_imm              = '0;
    for (int r = 0; r < `RV32I_NUM_ARCH_REGS; r++) begin
      model[r]    = '0;
      expected[r] = '0;
      pending[r]  = 1'b0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;

    // Immediate loads into x1..x8
    for (int r = 1; r <= 8; r++) begin
      imm = rand_bits(32);
      send(rv32i_exec_pkg::PU_ADD, 1'b0, '0, 1'b0, '0, rv32i_arch_pkg::reg_idx_t'(r), imm);
    end
    finish_test("immediate loads");

    for (int i = 0; i < 8; i++) begin
      s1 = pick_reg(3);
      s2 = pick_reg(3);
      send(rv32i_exec_pkg::PU_ADD, 1'b1, s1, 1'b1, s2,
           rv32i_arch_pkg::reg_idx_t'(9 + i), '0);
    end
    finish_test("register add");

    for (int i = 0; i < 8; i++) begin
      s1 = pick_reg(4);
      s2 = pick_reg(4);
      send(rv32i_exec_pkg::PU_MULT, 1'b1, s1, 1'b1, s2,
           rv32i_arch_pkg::reg_idx_t'(17 + i), '0);
    end
    finish_test("multiply");

    // Each source is the previous destination
    s1 = rv32i_arch_pkg::reg_idx_t'(1);
    for (int i = 0; i < 8; i++) begin
      pu  = pick_pu();
      v2  = 1'(rand_bits(1));
      s2  = pick_reg(3);
      imm = rand_bits(32);
      dst = rv32i_arch_pkg::reg_idx_t'(24 + i);
      send(pu, 1'b1, s1, v2, s2, dst, imm);
      s1 = dst;
    end
    finish_test("dependent chain");

    for (int i = 0; i < 40; i++) begin
      pu  = pick_pu();
      v1  = 1'(rand_bits(1));
      s1  = rv32i_arch_pkg::reg_idx_t'(rand_bits(5));
      v2  = 1'(rand_bits(1));
      s2  = rv32i_arch_pkg::reg_idx_t'(rand_bits(5));
      dst = pick_reg(3);
      imm = rand_bits(32);
      send(pu, v1, s1, v2, s2, dst, imm);
    end
    finish_test("random contention");

    // Busy destination, then a multiplier chain that fills its station
    imm = rand_bits(32);
    send(rv32i_exec_pkg::PU_ADD, 1'b0, '0, 1'b0, '0, 5'd5, imm);
    send(rv32i_exec_pkg::PU_MULT, 1'b1, 5'd5, 1'b1, 5'd5, 5'd5, '0);
    send(rv32i_exec_pkg::PU_MULT, 1'b1, 5'd1, 1'b1, 5'd2, 5'd10, '0);
    send(rv32i_exec_pkg::PU_MULT, 1'b1, 5'd10, 1'b1, 5'd10, 5'd11, '0);
    send(rv32i_exec_pkg::PU_MULT, 1'b1, 5'd11, 1'b1, 5'd1, 5'd12, '0);
    send(rv32i_exec_pkg::PU_MULT, 1'b1, 5'd12, 1'b1, 5'd2, 5'd13, '0);
    finish_test("destination stall");

    assert (n_wb == n_accepted) else begin
      $display("Mismatch write-back count: got 0x%08h expected 0x%08h", n_wb, n_accepted);
      errors++;
    end
    $display("tests %0d, instructions %0d, write-backs %0d, errors %0d",
             tests_run, n_accepted, n_wb, total_errors());
    if (total_errors() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
